/* mdu.f */
+incdir+sim
hw/mdu_pkg.sv
hw/mdu_multiplier.sv
hw/mdu_divider.sv
hw/mdu_pipe.sv
hw/mdu_top.sv
sim/mdu_tb.sv

/* Bender.yml */
package:
  name: mdu

sources:
  - files:
      - hw/mdu_pkg.sv
      - hw/mdu_multiplier.sv
      - hw/mdu_divider.sv
      - hw/mdu_pipe.sv
      - hw/mdu_top.sv

  - target: test
    include_dirs:
      - sim
    files:
      - sim/mdu_tb.sv

/* sim/mdu_ref.svh */
/*
 * Reference model for one multiply/divide micro-op, included into the
 * testbench module. Returns the word the pipe is expected to write back.
 */
`ifndef MDU_REF_SVH
`define MDU_REF_SVH

function automatic logic [mdu_pkg::XLEN-1:0] mdu_ref(input mdu_pkg::mdu_op_e op,
                                                     input logic signed_op,
                                                     input logic [mdu_pkg::XLEN-1:0] src0,
                                                     input logic [mdu_pkg::XLEN-1:0] src1);
  logic [63:0] a_ext;  // 64-bit extended operands
  logic [63:0] b_ext;
  logic [63:0] prod;   // exact product modulo 2^64
  logic [31:0] quo;
  logic [31:0] rem;

  a_ext = signed_op ? {{32{src0[31]}}, src0} : {32'h0, src0};
  b_ext = signed_op ? {{32{src1[31]}}, src1} : {32'h0, src1};
  prod  = a_ext * b_ext;

  if (src1 == 32'h0) begin
    quo = 32'hffff_ffff;  // divide by zero
    rem = src0;
  end else if (signed_op && src0 == 32'h8000_0000 && src1 == 32'hffff_ffff) begin
    quo = 32'h8000_0000;  // signed overflow
    rem = 32'h0;
  end else if (signed_op) begin
    quo = $signed(src0) / $signed(src1);  // truncates toward zero
    rem = $signed(src0) % $signed(src1);  // sign of dividend
  end else begin
    quo = src0 / src1;
    rem = src0 % src1;
  end

  case (op)
    mdu_pkg::MDU_MUL:  return prod[31:0];
    mdu_pkg::MDU_MULH: return prod[63:32];
    mdu_pkg::MDU_DIV:  return quo;
    default:           return rem;
  endcase
endfunction

`endif

/* sim/mdu_tb.sv */
/*
 * Testbench for the multiply/divide pipe. Issues directed and random
 * micro-ops, stalls the commit side at random, flushes during divides and
 * checks every writeback against the reference model, in issue order.
 */
`timescale 1ns/1ps

module mdu_tb;

  localparam int CLK_HALF = 20;   // 40 ns clock
  localparam int TIMEOUT  = 200;  // cycles per handshake wait

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  logic              ready_o;
  logic              wb_ready_i;
  mdu_pkg::mdu_exe_t exe_i;
  mdu_pkg::mdu_wb_t  wb_o;

  mdu_pkg::wb_base_t exp_q [$];  // expected writebacks, oldest first
  mdu_pkg::wb_base_t exp_wb;
  mdu_pkg::mdu_wb_t  wb_prev;    // wb_o at the previous edge
  logic              wb_stalled_q;
  logic              flush_q;
  logic              bp_en;      // back-pressure process active
  logic              hung;       // some wait ran out
  int                stall_left;
  int                mismatches;
  int                timeouts;
  int                other_errs;
  int                issued;
  int                written;
  int                flushed;

  `include "mdu_ref.svh"

  mdu_top #(
    .MULT_STAGES (3)
  ) i_mdu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  always #CLK_HALF clk = ~clk;

  // ==========================================================================
  // back-pressure, random stalls of 1 to 10 cycles
  // ==========================================================================
  always @(negedge clk) begin
    if (!bp_en) begin
      wb_ready_i = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
      wb_ready_i = 1'b0;
    end else if ($urandom % 4 == 0) begin
      stall_left = $urandom_range(1, 10) - 1;  // this cycle counts
      wb_ready_i = 1'b0;
    end else begin
      wb_ready_i = 1'b1;
    end
  end

  // ==========================================================================
  // compare, sampled on the rising edge
  // ==========================================================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (wb_stalled_q && !flush_q && wb_o !== wb_prev) begin
        $display("Mismatch at %0t: wb_o under back-pressure expected %h actual %h",
                 $time, wb_prev, wb_o);
        mismatches++;
      end
      if (wb_o.base.valid && !wb_ready_i && !flush_i && ready_o !== 1'b0) begin
        $display("Mismatch at %0t: ready_o under back-pressure expected 0 actual %b",
                 $time, ready_o);
        mismatches++;
      end
      if (wb_o.base.valid && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: writeback with no outstanding micro-op", $time);
          other_errs++;
        end else begin
          exp_wb = exp_q.pop_front();
          written++;
          if (wb_o.base.wdata !== exp_wb.wdata) begin
            $display("Mismatch at %0t: wb_o.base.wdata expected %h actual %h",
                     $time, exp_wb.wdata, wb_o.base.wdata);
            mismatches++;
          end
          if (wb_o.base.we !== exp_wb.we) begin
            $display("Mismatch at %0t: wb_o.base.we expected %b actual %b",
                     $time, exp_wb.we, wb_o.base.we);
            mismatches++;
          end
          if (wb_o.base.pdest !== exp_wb.pdest) begin
            $display("Mismatch at %0t: wb_o.base.pdest expected %h actual %h",
                     $time, exp_wb.pdest, wb_o.base.pdest);
            mismatches++;
          end
          if (wb_o.base.rob_idx !== exp_wb.rob_idx) begin
            $display("Mismatch at %0t: wb_o.base.rob_idx expected %h actual %h",
                     $time, exp_wb.rob_idx, wb_o.base.rob_idx);
            mismatches++;
          end
        end
      end
    end
    wb_prev      = wb_o;
    wb_stalled_q = rst_n && wb_o.base.valid && !wb_ready_i;
    flush_q      = flush_i;
  end

  // ==========================================================================
  // stimulus helpers, all start and end on a falling edge
  // ==========================================================================
  function automatic logic [31:0] pick_operand();
    case ($urandom % 8)
      0:       return 32'h0;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;  // most negative
      3:       return 32'h1;
      default: return $urandom;
    endcase
  endfunction

  task automatic issue_op(input mdu_pkg::mdu_op_e op, input logic sgn,
                          input logic [31:0] a, input logic [31:0] b);
    mdu_pkg::mdu_exe_t uop;
    mdu_pkg::wb_base_t exp;
    int                waited;
    uop.base.valid       = 1'b1;
    uop.base.src0        = a;
    uop.base.src1        = b;
    uop.base.pdest_valid = $urandom % 2;
    uop.base.pdest       = $urandom;
    uop.base.rob_idx     = $urandom;
    uop.oc.op            = op;
    uop.oc.signed_op     = sgn;
    exe_i  = uop;
    waited = 0;
    @(posedge clk);
    while (!ready_o && waited < TIMEOUT) begin  // handshake seen at this edge
      waited++;
      @(posedge clk);
    end
    if (ready_o) begin
      exp.valid   = 1'b1;
      exp.we      = uop.base.pdest_valid;
      exp.pdest   = uop.base.pdest;
      exp.wdata   = mdu_ref(op, sgn, a, b);
      exp.rob_idx = uop.base.rob_idx;
      exp_q.push_back(exp);
      issued++;
    end else begin
      $display("Error at %0t: timeout, micro-op never accepted", $time);
      timeouts++;
      hung = 1'b1;
    end
    @(negedge clk);
    exe_i.base.valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Error at %0t: timeout, %0d results never written back", $time, exp_q.size());
      timeouts++;
      hung = 1'b1;
    end
  endtask

  task automatic directed_cases();
    logic [31:0] ca [0:7];
    logic [31:0] cb [0:7];
    ca[0] = 32'h8000_0000;  // overflow case
    cb[0] = 32'hffff_ffff;
    ca[1] = 32'h1234_5678;  // divide by zero
    cb[1] = 32'h0;
    ca[2] = 32'h0;
    cb[2] = 32'h0;
    ca[3] = 32'hffff_ffff;
    cb[3] = 32'hffff_ffff;
    ca[4] = 32'h8000_0000;
    cb[4] = 32'h8000_0000;
    ca[5] = 32'h7fff_ffff;
    cb[5] = 32'h2;
    ca[6] = 32'hffff_fff9;  // -7 by 2
    cb[6] = 32'h2;
    ca[7] = 32'h5;
    cb[7] = 32'hffff_fffe;
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < 2; s++) begin
        for (int p = 0; p < 8 && !hung; p++) begin
          issue_op(mdu_pkg::mdu_op_e'(k), s[0], ca[p], cb[p]);
        end
      end
    end
    drain();
  endtask

  // kind 0 multiplies, 1 divides, else any op
  task automatic run_random(input int n, input int kind);
    mdu_pkg::mdu_op_e op;
    for (int i = 0; i < n && !hung; i++) begin
      case (kind)
        0:       op = ($urandom % 2) ? mdu_pkg::MDU_MULH : mdu_pkg::MDU_MUL;
        1:       op = ($urandom % 2) ? mdu_pkg::MDU_MOD : mdu_pkg::MDU_DIV;
        default: op = mdu_pkg::mdu_op_e'($urandom_range(0, 3));
      endcase
      issue_op(op, $urandom % 2, pick_operand(), pick_operand());
      if ($urandom % 4 == 0) begin
        repeat ($urandom_range(1, 3)) @(negedge clk);  // idle gap
      end
    end
    drain();
  endtask

  // kill a divide in flight, then check the pipe still works
  task automatic flush_divide();
    drain();
    issue_op(($urandom % 2) ? mdu_pkg::MDU_MOD : mdu_pkg::MDU_DIV, $urandom % 2,
             $urandom, pick_operand());
    repeat ($urandom_range(1, 20)) @(negedge clk);  // well inside 34 cycles
    if (wb_o.base.valid !== 1'b0) begin
      $display("Error at %0t: divide result showed up before the flush", $time);
      other_errs++;
    end
    flush_i = 1'b1;
    if (exp_q.size() != 0) begin
      exp_q.delete(exp_q.size() - 1);  // never written back
      flushed++;
    end
    @(negedge clk);
    flush_i = 1'b0;
    @(posedge clk);
    if (ready_o !== 1'b1) begin
      $display("Mismatch at %0t: ready_o after flush expected 1 actual %b", $time, ready_o);
      mismatches++;
    end
    @(negedge clk);
    issue_op(mdu_pkg::MDU_DIV, $urandom % 2, $urandom, pick_operand());
    drain();
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    void'($urandom(30));
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    exe_i        = '0;
    wb_ready_i   = 1'b1;
    bp_en        = 1'b0;
    hung         = 1'b0;
    stall_left   = 0;
    wb_prev      = '0;
    wb_stalled_q = 1'b0;
    flush_q      = 1'b0;
    mismatches   = 0;
    timeouts     = 0;
    other_errs   = 0;
    issued       = 0;
    written      = 0;
    flushed      = 0;
    clk          = 1'b0;  // last, so the negedge process sees bp_en low

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    if (ready_o !== 1'b1) begin
      $display("Mismatch at %0t: ready_o after reset expected 1 actual %b", $time, ready_o);
      mismatches++;
    end
    if (wb_o.base.valid !== 1'b0) begin
      $display("Mismatch at %0t: wb_o.base.valid after reset expected 0 actual %b",
               $time, wb_o.base.valid);
      mismatches++;
    end
    @(negedge clk);

    bp_en = 1'b1;
    directed_cases();
    run_random(150, 0);
    run_random(100, 1);
    for (int f = 0; f < 4 && !hung; f++) begin
      flush_divide();
    end
    run_random(60, 2);
    drain();

    if (issued != written + flushed) begin
      $display("Error: %0d issued but %0d written back and %0d flushed",
               issued, written, flushed);
      other_errs++;
    end
    $display("summary: %0d written, %0d flushed, %0d mismatches, %0d timeouts, %0d other errors",
             written, flushed, mismatches, timeouts, other_errs);
    if (mismatches == 0 && timeouts == 0 && other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hw/mdu_top.sv */
/*
 * Top level of the multiply/divide pipe. Fixes the multiplier depth and
 * exposes the issue and writeback handshakes to the surrounding core.
 */
`timescale 1ns/1ps

module mdu_top #(
  parameter int MULT_STAGES = 3  // multiplier depth, 1 to 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,     // one-cycle pulse, kills in-flight op

  // issue side
  input  mdu_pkg::mdu_exe_t exe_i,
  output logic              ready_o,

  // commit side
  output mdu_pkg::mdu_wb_t  wb_o,
  input  logic              wb_ready_i
);

  // ==========================================================================
  // execution pipe
  // ==========================================================================
  mdu_pipe #(
    .MULT_STAGES (MULT_STAGES)
  ) i_mdu_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

endmodule

/* hw/mdu_pipe.sv */
/*
 * Two-stage control for the multiply/divide pipe. Stage 1 latches the issued
 * micro-op, dispatches it to one unit, waits for the response and holds the
 * selected result word until the commit side takes it.
 */
`timescale 1ns/1ps

module mdu_pipe #(
  parameter int MULT_STAGES = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  mdu_pkg::mdu_exe_t exe_i,
  output logic              ready_o,
  output mdu_pkg::mdu_wb_t  wb_o,
  input  logic              wb_ready_i
);

  typedef enum logic {
    S_IDLE,  // nothing outstanding at a unit
    S_WAIT   // request taken, waiting on rsp.valid
  } pipe_state_e;

  pipe_state_e state_q;

  logic                    s1_vld_q;   // stage 1 occupied
  mdu_pkg::mdu_exe_t       s1_q;       // latched micro-op, payload only
  logic                    res_vld_q;  // result word captured
  logic [mdu_pkg::XLEN-1:0] res_q;

  logic is_mul;      // op goes to the multiplier
  logic dispatch;    // stage 1 still needs a unit
  logic req_fire;    // unit took the request
  logic unit_done;   // selected unit has its result
  logic wb_fire;     // writeback handshake
  logic accept;      // issue handshake

  mdu_pkg::mult_req_t mult_req;
  mdu_pkg::mult_rsp_t mult_rsp;
  mdu_pkg::div_req_t  div_req;
  mdu_pkg::div_rsp_t  div_rsp;

  // ==========================================================================
  // stage 0: handshake
  // ==========================================================================
  assign wb_fire = wb_o.base.valid & wb_ready_i;
  // free slot, or slot drains this cycle; nothing enters during flush
  assign ready_o = (~s1_vld_q | wb_fire) & ~flush_i;
  assign accept  = exe_i.base.valid & ready_o;

  // ==========================================================================
  // stage 1: latch, dispatch, wait
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
    end else if (flush_i) begin
      s1_vld_q <= 1'b0;
    end else if (ready_o) begin
      s1_vld_q <= exe_i.base.valid;  // empty slot if nothing issued
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_q <= exe_i;
    end
  end

  assign is_mul   = (s1_q.oc.op == mdu_pkg::MDU_MUL) | (s1_q.oc.op == mdu_pkg::MDU_MULH);
  assign dispatch = s1_vld_q & ~res_vld_q & (state_q == S_IDLE);

  always_comb begin
    mult_req.valid        = dispatch & is_mul;
    mult_req.mul_signed   = s1_q.oc.signed_op;
    mult_req.multiplicand = s1_q.base.src0;
    mult_req.multiplier   = s1_q.base.src1;

    div_req.valid      = dispatch & ~is_mul;
    div_req.div_signed = s1_q.oc.signed_op;
    div_req.dividend   = s1_q.base.src0;
    div_req.divisor    = s1_q.base.src1;
  end

  assign req_fire  = (mult_req.valid & mult_rsp.ready) | (div_req.valid & div_rsp.ready);
  assign unit_done = is_mul ? mult_rsp.valid : div_rsp.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      res_vld_q <= 1'b0;
    end else if (flush_i) begin
      state_q   <= S_IDLE;  // units drop their work the same edge
      res_vld_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (req_fire) state_q <= S_WAIT;
        S_WAIT: if (unit_done) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
      if (wb_fire) begin
        res_vld_q <= 1'b0;
      end else if (state_q == S_WAIT && unit_done) begin
        res_vld_q <= 1'b1;  // held until the commit side takes it
      end
    end
  end

  // op picks the response word
  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && unit_done) begin
      case (s1_q.oc.op)
        mdu_pkg::MDU_MUL:  res_q <= mult_rsp.res_lo;
        mdu_pkg::MDU_MULH: res_q <= mult_rsp.res_hi;
        mdu_pkg::MDU_DIV:  res_q <= div_rsp.quotient;
        default:           res_q <= div_rsp.remainder;
      endcase
    end
  end

  // everything on wb_o comes from registers, so it holds under back-pressure
  always_comb begin
    wb_o.base.valid   = s1_vld_q & res_vld_q;
    wb_o.base.we      = s1_q.base.pdest_valid;
    wb_o.base.pdest   = s1_q.base.pdest;
    wb_o.base.wdata   = res_q;
    wb_o.base.rob_idx = s1_q.base.rob_idx;
  end

  // ==========================================================================
  // units
  // ==========================================================================
  mdu_multiplier #(
    .MULT_STAGES (MULT_STAGES)
  ) i_mdu_multiplier (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (flush_i),
    .req_i     (mult_req),
    .consume_i (wb_fire),  // idle unit ignores it
    .rsp_o     (mult_rsp)
  );

  mdu_divider i_mdu_divider (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_i   (flush_i),
    .req_i     (div_req),
    .consume_i (wb_fire),
    .rsp_o     (div_rsp)
  );

  // writeback word frozen while the commit side stalls
  a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_o.base.valid && !wb_ready_i && !flush_i) |=> $stable(wb_o));

  // at most one unit holds an accepted request at any time
  a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
    mult_rsp.ready || div_rsp.ready);

endmodule

/* hw/mdu_divider.sv */
/*
 * Radix-2 restoring divider. One prep cycle for magnitudes and signs,
 * 32 shift-subtract steps, one fix-up cycle; result held until consumed.
 */
`timescale 1ns/1ps

module mdu_divider (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  mdu_pkg::div_req_t req_i,
  input  logic              consume_i,
  output mdu_pkg::div_rsp_t rsp_o
);

  localparam int XLEN = mdu_pkg::XLEN;

  typedef enum logic [2:0] {
    D_IDLE,  // ready for a request
    D_PREP,  // magnitudes, signs, special cases
    D_ITER,  // 32 shift-subtract steps
    D_FIX,   // sign fix-up
    D_DONE   // result held
  } div_state_e;

  div_state_e      state_q;
  logic [5:0]      cnt_q;     // iteration count, 0..32
  logic            accept;

  logic [XLEN-1:0] dvd_q;     // raw dividend, kept for div by zero
  logic [XLEN-1:0] dvs_q;     // raw divisor, then its magnitude
  logic [XLEN-1:0] quo_q;     // dividend bits shift out, quotient bits in
  logic [XLEN-1:0] rem_q;
  logic            sgn_q;
  logic            q_neg_q;
  logic            r_neg_q;
  logic            div0_q;
  logic            ovf_q;     // most negative / -1

  logic [XLEN-1:0] dvd_abs;
  logic [XLEN-1:0] dvs_abs;
  logic [XLEN:0]   rem_sh;    // partial remainder with next dividend bit
  logic [XLEN+1:0] diff;      // top bit is the borrow
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  assign accept = req_i.valid & (state_q == D_IDLE);

  // ==========================================================================
  // datapath helpers
  // ==========================================================================
  always_comb begin
    dvd_abs = (sgn_q & dvd_q[XLEN-1]) ? -dvd_q : dvd_q;
    dvs_abs = (sgn_q & dvs_q[XLEN-1]) ? -dvs_q : dvs_q;

    rem_sh = {rem_q, quo_q[XLEN-1]};
    diff   = {1'b0, rem_sh} - {2'b00, dvs_q};

    // special cases override the sign fix
    if (div0_q) begin
      quo_fix = '1;
      rem_fix = dvd_q;
    end else if (ovf_q) begin
      quo_fix = {1'b1, {(XLEN-1){1'b0}}};
      rem_fix = '0;
    end else begin
      quo_fix = q_neg_q ? -quo_q : quo_q;
      rem_fix = r_neg_q ? -rem_q : rem_q;
    end
  end

  // ==========================================================================
  // control
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= D_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= D_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        D_IDLE: if (accept) state_q <= D_PREP;
        D_PREP: begin
          state_q <= D_ITER;
          cnt_q   <= '0;
        end
        D_ITER: begin
          cnt_q <= cnt_q + 6'd1;
          if (cnt_q == 6'd31) state_q <= D_FIX;  // last step
        end
        D_FIX:  state_q <= D_DONE;
        D_DONE: if (consume_i) state_q <= D_IDLE;
        default: state_q <= D_IDLE;
      endcase
    end
  end

  // ==========================================================================
  // datapath registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    case (state_q)
      D_IDLE: begin
        if (accept) begin
          dvd_q <= req_i.dividend;
          dvs_q <= req_i.divisor;
          sgn_q <= req_i.div_signed;
        end
      end
      D_PREP: begin
        quo_q   <= dvd_abs;
        dvs_q   <= dvs_abs;
        rem_q   <= '0;
        q_neg_q <= sgn_q & (dvd_q[XLEN-1] ^ dvs_q[XLEN-1]);
        r_neg_q <= sgn_q & dvd_q[XLEN-1];  // remainder follows dividend
        div0_q  <= (dvs_q == '0);
        ovf_q   <= sgn_q & (dvd_q == {1'b1, {(XLEN-1){1'b0}}}) & (dvs_q == '1);
      end
      D_ITER: begin
        if (!diff[XLEN+1]) begin
          rem_q <= diff[XLEN-1:0];  // fits, keep the difference
          quo_q <= {quo_q[XLEN-2:0], 1'b1};
        end else begin
          rem_q <= rem_sh[XLEN-1:0];  // restore
          quo_q <= {quo_q[XLEN-2:0], 1'b0};
        end
      end
      D_FIX: begin
        quo_q <= quo_fix;
        rem_q <= rem_fix;
      end
      default: ;
    endcase
  end

  always_comb begin
    rsp_o.ready     = (state_q == D_IDLE);
    rsp_o.valid     = (state_q == D_DONE);
    rsp_o.quotient  = quo_q;
    rsp_o.remainder = rem_q;
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= 6'd32);

endmodule

/* hw/mdu_multiplier.sv */
/*
 * Pipelined 33x33 signed multiplier. One operation in flight; the 64-bit
 * product is held in an output register until the pipe consumes it.
 */
`timescale 1ns/1ps

module mdu_multiplier #(
  parameter int MULT_STAGES = 3  // 1 to 4 register stages
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  mdu_pkg::mult_req_t req_i,
  input  logic               consume_i,  // writeback took the result
  output mdu_pkg::mult_rsp_t rsp_o
);

  localparam int XLEN = mdu_pkg::XLEN;

  logic signed [XLEN:0]     op_a;       // sign/zero extended
  logic signed [XLEN:0]     op_b;
  logic signed [2*XLEN+1:0] prod_full;  // 66 bits, top two unused
  logic                     accept;

  logic [2*XLEN-1:0]        stg_q [MULT_STAGES];
  logic [MULT_STAGES-1:0]   stg_vld_q;
  logic [2*XLEN-1:0]        res_q;
  logic                     res_vld_q;
  logic                     busy_q;     // from accept until consume

  // ==========================================================================
  // operand extension and product
  // ==========================================================================
  assign op_a      = {req_i.mul_signed & req_i.multiplicand[XLEN-1], req_i.multiplicand};
  assign op_b      = {req_i.mul_signed & req_i.multiplier[XLEN-1], req_i.multiplier};
  assign prod_full = op_a * op_b;

  assign accept = req_i.valid & ~busy_q;

  // ==========================================================================
  // stage registers
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_vld_q <= '0;
    end else if (flush_i) begin
      stg_vld_q <= '0;
    end else begin
      stg_vld_q[0] <= accept;
      for (int i = 1; i < MULT_STAGES; i++) begin
        stg_vld_q[i] <= stg_vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    stg_q[0] <= prod_full[2*XLEN-1:0];  // low 64 bits are exact
    for (int i = 1; i < MULT_STAGES; i++) begin
      stg_q[i] <= stg_q[i-1];
    end
  end

  // ==========================================================================
  // held result
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      res_vld_q <= 1'b0;
    end else if (flush_i) begin
      busy_q    <= 1'b0;
      res_vld_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (consume_i) begin
        busy_q <= 1'b0;
      end
      if (stg_vld_q[MULT_STAGES-1]) begin
        res_vld_q <= 1'b1;
      end else if (consume_i) begin
        res_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stg_vld_q[MULT_STAGES-1]) begin
      res_q <= stg_q[MULT_STAGES-1];
    end
  end

  always_comb begin
    rsp_o.ready  = ~busy_q;
    rsp_o.valid  = res_vld_q;
    rsp_o.res_lo = res_q[XLEN-1:0];
    rsp_o.res_hi = res_q[2*XLEN-1:XLEN];
  end

  // a new op only ever starts on an empty pipe and empty result register
  a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (stg_vld_q == '0) && !res_vld_q);

endmodule

/* hw/mdu_pkg.sv */
/*
 * Shared types for the multiply/divide execution pipe: widths, op encoding,
 * the issued micro-op, unit request/response structs and the writeback word.
 */
package mdu_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int XLEN    = 32;  // operand / result width
  localparam int PDEST_W = 6;   // physical dest tag
  localparam int ROB_W   = 5;   // rob index

  // op encoding, signedness travels separately
  typedef enum logic [1:0] {
    MDU_MUL  = 2'd0,  // low product word
    MDU_MULH = 2'd1,  // high product word
    MDU_DIV  = 2'd2,  // quotient
    MDU_MOD  = 2'd3   // remainder
  } mdu_op_e;

  // ==========================================================================
  // issued micro-op
  // ==========================================================================
  typedef struct packed {
    mdu_op_e op;
    logic    signed_op;  // 1: operands are two's complement
  } mdu_oc_t;

  typedef struct packed {
    logic               valid;
    logic [XLEN-1:0]    src0;
    logic [XLEN-1:0]    src1;
    logic               pdest_valid;  // write enable
    logic [PDEST_W-1:0] pdest;
    logic [ROB_W-1:0]   rob_idx;
  } exe_base_t;

  typedef struct packed {
    exe_base_t base;
    mdu_oc_t   oc;
  } mdu_exe_t;

  // ==========================================================================
  // unit interfaces
  // ==========================================================================
  typedef struct packed {
    logic            valid;
    logic            mul_signed;
    logic [XLEN-1:0] multiplicand;
    logic [XLEN-1:0] multiplier;
  } mult_req_t;

  typedef struct packed {
    logic            ready;   // idle, can take a request
    logic            valid;   // result held until consume
    logic [XLEN-1:0] res_lo;
    logic [XLEN-1:0] res_hi;
  } mult_rsp_t;

  typedef struct packed {
    logic            valid;
    logic            div_signed;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic            ready;
    logic            valid;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
  } div_rsp_t;

  // ==========================================================================
  // writeback
  // ==========================================================================
  typedef struct packed {
    logic               valid;
    logic               we;
    logic [PDEST_W-1:0] pdest;
    logic [XLEN-1:0]    wdata;
    logic [ROB_W-1:0]   rob_idx;
  } wb_base_t;

  typedef struct packed {
    wb_base_t base;
  } mdu_wb_t;

endpackage
